//--- src/wiscPkg.sv
//####################
// shared definitions for the execute slice
// instruction word union, opcodes,
// ALU codes, select encodings, status bit
//####################
package wiscPkg;

   // one 16-bit word, two decodes
   typedef union packed {
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [2:0] rd;      // imm8 is {rd, imm5}
         logic [4:0] imm5;
      } iForm;
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [2:0] rt;
         logic [2:0] rd;
         logic [1:0] func;
      } rForm;
   } wiscInstr;

   localparam logic [4:0] opHalt  = 5'b0_0000;
   localparam logic [4:0] opNop   = 5'b0_0001;
   localparam logic [4:0] opAddi  = 5'b0_1000;
   localparam logic [4:0] opSubi  = 5'b0_1001;
   localparam logic [4:0] opXori  = 5'b0_1010;
   localparam logic [4:0] opAndni = 5'b0_1011;
   localparam logic [4:0] opRoli  = 5'b1_0100;
   localparam logic [4:0] opSlli  = 5'b1_0101;
   localparam logic [4:0] opRori  = 5'b1_0110;
   localparam logic [4:0] opSrli  = 5'b1_0111;
   localparam logic [4:0] opSlbi  = 5'b1_0010;
   localparam logic [4:0] opLbi   = 5'b1_1000;
   localparam logic [4:0] opBtr   = 5'b1_1001;
   localparam logic [4:0] opShift = 5'b1_1010;  // ROL SLL ROR SRL by func
   localparam logic [4:0] opAlu   = 5'b1_1011;  // ADD SUB XOR ANDN by func
   localparam logic [4:0] opSeq   = 5'b1_1100;
   localparam logic [4:0] opSlt   = 5'b1_1101;
   localparam logic [4:0] opSle   = 5'b1_1110;
   localparam logic [4:0] opSco   = 5'b1_1111;

   localparam logic [2:0] aluAdd  = 3'd0;
   localparam logic [2:0] aluXor  = 3'd1;
   localparam logic [2:0] aluAndn = 3'd2;  // B already inverted by invB
   localparam logic [2:0] aluRol  = 3'd3;
   localparam logic [2:0] aluSll  = 3'd4;
   localparam logic [2:0] aluRor  = 3'd5;
   localparam logic [2:0] aluSrl  = 3'd6;
   localparam logic [2:0] aluBtr  = 3'd7;

   localparam logic [1:0] wbAlu  = 2'd0;
   localparam logic [1:0] wbSet  = 2'd1;
   localparam logic [1:0] wbImm8 = 2'd2;
   localparam logic [1:0] wbSlbi = 2'd3;

   localparam logic dstI = 1'b0;  // bits 7:5
   localparam logic dstR = 1'b1;  // bits 4:2

   localparam logic [2:0] condEq = 3'd0;
   localparam logic [2:0] condLt = 3'd1;
   localparam logic [2:0] condLe = 3'd2;
   localparam logic [2:0] condCo = 3'd3;

   localparam int statHalted = 0;

endpackage

//--- src/controlUnit.sv
//####################
// instruction decoder
// opcode and func to datapath controls
// plus the illegal-opcode flag
//####################
module controlUnit import wiscPkg::*; (
   input  wiscInstr   instr,
   output logic [2:0] aluOp,
   output logic       immB,     // B operand from imm5
   output logic       zeroExt,  // zero extend imm5
   output logic       invA,
   output logic       invB,
   output logic       cin,
   output logic       regWrt,
   output logic [1:0] wbSel,
   output logic       dstSel,
   output logic [2:0] condSel,
   output logic       halt,
   output logic       illegal
);

   logic [4:0] opcode;
   logic [1:0] func;

   assign opcode = instr.iForm.opcode;
   assign func   = instr.rForm.func;  // only meaningful for reg ALU groups

   always_comb begin
      aluOp   = aluAdd;
      immB    = 1'b0;
      zeroExt = 1'b0;
      invA    = 1'b0;
      invB    = 1'b0;
      cin     = 1'b0;
      regWrt  = 1'b0;
      wbSel   = wbAlu;
      dstSel  = dstI;
      condSel = condEq;
      halt    = 1'b0;
      illegal = 1'b0;
      case (opcode)
         opHalt: begin
            halt = 1'b1;  // sticky flag set in the bus slave
         end
         opNop: begin
            // nothing to write
         end
         opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
            regWrt  = 1'b1;
            immB    = 1'b1;
            zeroExt = (opcode != opAddi) && (opcode != opSubi);  // add/sub sign extend
            case (opcode)
               opSubi: begin
                  invA = 1'b1;  // imm5 - rs
                  cin  = 1'b1;
               end
               opXori:  aluOp = aluXor;
               opAndni: begin
                  aluOp = aluAndn;
                  invB  = 1'b1;  // rs & ~imm
               end
               opRoli:  aluOp = aluRol;
               opSlli:  aluOp = aluSll;
               opRori:  aluOp = aluRor;
               opSrli:  aluOp = aluSrl;
               default: aluOp = aluAdd;  // ADDI
            endcase
         end
         opAlu: begin
            regWrt = 1'b1;
            dstSel = dstR;
            case (func)
               2'b01: begin
                  invA = 1'b1;  // SUB is rt - rs
                  cin  = 1'b1;
               end
               2'b10: aluOp = aluXor;
               2'b11: begin
                  aluOp = aluAndn;
                  invB  = 1'b1;
               end
               default: aluOp = aluAdd;
            endcase
         end
         opShift: begin
            regWrt = 1'b1;
            dstSel = dstR;
            case (func)
               2'b00:   aluOp = aluRol;
               2'b01:   aluOp = aluSll;
               2'b10:   aluOp = aluRor;
               default: aluOp = aluSrl;
            endcase
         end
         opBtr: begin
            regWrt = 1'b1;
            dstSel = dstR;
            aluOp  = aluBtr;
         end
         opSeq, opSlt, opSle, opSco: begin
            regWrt = 1'b1;
            dstSel = dstR;
            wbSel  = wbSet;
            invB   = 1'b1;  // adder forms rs - rt
            cin    = 1'b1;
            case (opcode)
               opSlt:   condSel = condLt;
               opSle:   condSel = condLe;
               opSco:   condSel = condCo;
               default: condSel = condEq;
            endcase
         end
         opLbi: begin
            regWrt = 1'b1;
            wbSel  = wbImm8;  // dest is rs
         end
         opSlbi: begin
            regWrt = 1'b1;
            wbSel  = wbSlbi;
         end
         default: begin
            illegal = 1'b1;  // memory, branch, jump, siic, RTI, undefined
         end
      endcase
   end

endmodule

//--- src/regFile.sv
//####################
// register file, 8 x 16 bits
// two operand reads, one write, host read
//####################
module regFile (
   input  logic        clk,
   input  logic        rstN,
   input  logic [2:0]  rsAddr,
   input  logic [2:0]  rtAddr,
   output logic [15:0] rsData,
   output logic [15:0] rtData,
   input  logic        wrEn,
   input  logic [2:0]  wrAddr,
   input  logic [15:0] wrData,
   input  logic [2:0]  hostAddr,
   output logic [15:0] hostData
);

   logic [15:0] regs [8];

   // write lands on the ack edge
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;  // all registers read zero after reset
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   assign rsData   = regs[rsAddr];    // operand A
   assign rtData   = regs[rtAddr];    // operand B
   assign hostData = regs[hostAddr];  // bus read path

endmodule

//--- src/executeUnit.sv
//####################
// execute datapath
// ALU, shifter, set conditions,
// write-back and destination select
//####################
module executeUnit import wiscPkg::*; (
   input  wiscInstr    instr,
   input  logic [2:0]  aluOp,
   input  logic        immB,
   input  logic        zeroExt,
   input  logic        invA,
   input  logic        invB,
   input  logic        cin,
   input  logic        regWrt,
   input  logic [1:0]  wbSel,
   input  logic        dstSel,
   input  logic [2:0]  condSel,
   input  logic        halt,
   input  logic        issue,     // acked instruction this cycle
   input  logic [15:0] rsData,
   input  logic [15:0] rtData,
   output logic        wrEn,
   output logic [2:0]  wrAddr,
   output logic [15:0] wrData,
   output logic        haltReq
);

   logic [7:0]  imm8;
   logic [15:0] immExt, bOp, aIn, bIn, sum, aluRes;
   logic [16:0] addFull;
   logic [31:0] rolFull, rorFull;
   logic [3:0]  shamt;
   logic        cout, zeroF, ovf, ltF, setBit;

   assign imm8   = {instr.iForm.rd, instr.iForm.imm5};
   assign immExt = zeroExt ? {11'b0, instr.iForm.imm5}
                           : {{11{instr.iForm.imm5[4]}}, instr.iForm.imm5};
   assign bOp    = immB ? immExt : rtData;
   assign aIn    = invA ? ~rsData : rsData;
   assign bIn    = invB ? ~bOp : bOp;

   assign addFull = {1'b0, aIn} + {1'b0, bIn} + {16'b0, cin};
   assign sum     = addFull[15:0];
   assign cout    = addFull[16];

   assign shamt   = bOp[3:0];               // low 4 bits only
   assign rolFull = {rsData, rsData} << shamt;
   assign rorFull = {rsData, rsData} >> shamt;

   always_comb begin
      case (aluOp)
         aluXor:  aluRes = aIn ^ bIn;
         aluAndn: aluRes = aIn & bIn;       // invB did the NOT
         aluRol:  aluRes = rolFull[31:16];
         aluSll:  aluRes = rsData << shamt;
         aluRor:  aluRes = rorFull[15:0];
         aluSrl:  aluRes = rsData >> shamt;
         aluBtr:  aluRes = {<<{rsData}};    // bit reverse
         default: aluRes = sum;
      endcase
   end

   // flags of rs + ~rt + 1
   assign zeroF = (sum == 16'h0000);
   assign ovf   = (aIn[15] == bIn[15]) && (sum[15] != aIn[15]);
   assign ltF   = sum[15] ^ ovf;            // signed less than

   always_comb begin
      case (condSel)
         condEq:  setBit = zeroF;
         condLt:  setBit = ltF;
         condLe:  setBit = ltF | zeroF;
         condCo:  setBit = cout;
         default: setBit = 1'b0;
      endcase
   end

   always_comb begin
      case (wbSel)
         wbSet:   wrData = {15'b0, setBit};
         wbImm8:  wrData = {{8{imm8[7]}}, imm8};  // LBI
         wbSlbi:  wrData = {rsData[7:0], imm8};
         default: wrData = aluRes;
      endcase
   end

   // LBI and SLBI write back into rs
   assign wrAddr = ((wbSel == wbImm8) || (wbSel == wbSlbi)) ? instr.iForm.rs :
                   (dstSel == dstR) ? instr.rForm.rd : instr.iForm.rd;

   assign wrEn    = regWrt & issue;
   assign haltReq = halt & issue;

endmodule

//--- src/wbSlave.sv
//####################
// Wishbone classic slave
// address decode, ack/err, read data,
// sticky halted flag
//####################
module wbSlave import wiscPkg::*; #(
   parameter int ADDR_WIDTH = 8
) (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  cyc,
   input  logic                  stb,
   input  logic                  we,
   input  logic [ADDR_WIDTH-1:0] adr,
   input  logic [15:0]           datW,
   output logic [15:0]           datR,
   output logic                  ack,
   output logic                  err,
   output wiscInstr              instrWord,
   output logic                  issue,
   output logic [2:0]            hostAddr,
   input  logic                  illegal,
   input  logic                  haltReq,
   input  logic [15:0]           hostData
);

   logic        halted;
   logic        req, isInstr, isStatRd, isRegRd, good;
   logic [15:0] status;

   assign req      = cyc & stb & ~ack & ~err;       // new request, not yet answered
   assign isInstr  = we & (adr == '0);
   assign isStatRd = ~we & (adr == '0);
   assign isRegRd  = ~we & (adr[ADDR_WIDTH-1:3] == 1);  // 8..15
   assign good     = isInstr ? (~illegal & ~halted) : (isStatRd | isRegRd);

   assign issue     = req & isInstr & ~illegal & ~halted;
   assign instrWord = datW;
   assign hostAddr  = adr[2:0];

   always_comb begin
      status             = '0;
      status[statHalted] = halted;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         ack    <= 1'b0;
         err    <= 1'b0;
         halted <= 1'b0;
      end else begin
         ack <= req & good;
         err <= req & ~good;
         if (haltReq) halted <= 1'b1;  // held until reset
      end
   end

   always_ff @(posedge clk) begin
      if (req & ~we) datR <= isStatRd ? status : hostData;
   end

endmodule

//--- src/wiscCore.sv
//####################
// execute slice top level
// bus slave, decoder, register file, datapath
//####################
module wiscCore import wiscPkg::*; #(
   parameter int ADDR_WIDTH = 8
) (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  cyc,
   input  logic                  stb,
   input  logic                  we,
   input  logic [ADDR_WIDTH-1:0] adr,
   input  logic [15:0]           datW,
   output logic [15:0]           datR,
   output logic                  ack,
   output logic                  err
);

   wiscInstr    instrWord;
   logic        issue, illegal, haltReq;
   logic [2:0]  hostAddr;
   logic [15:0] hostData, rsData, rtData, wrData;
   logic [2:0]  aluOp, condSel, wrAddr;
   logic [1:0]  wbSel;
   logic        immB, zeroExt, invA, invB, cin, regWrt, dstSel, halt, wrEn;

   wbSlave #(.ADDR_WIDTH(ADDR_WIDTH)) uBus (
      .clk, .rstN, .cyc, .stb, .we, .adr, .datW, .datR, .ack, .err,
      .instrWord, .issue, .hostAddr, .illegal, .haltReq, .hostData
   );

   controlUnit uCtrl (
      .instr(instrWord), .aluOp, .immB, .zeroExt, .invA, .invB, .cin,
      .regWrt, .wbSel, .dstSel, .condSel, .halt, .illegal
   );

   regFile uRegs (
      .clk, .rstN,
      .rsAddr(instrWord.rForm.rs), .rtAddr(instrWord.rForm.rt),
      .rsData, .rtData, .wrEn, .wrAddr, .wrData, .hostAddr, .hostData
   );

   executeUnit uExec (
      .instr(instrWord), .aluOp, .immB, .zeroExt, .invA, .invB, .cin,
      .regWrt, .wbSel, .dstSel, .condSel, .halt, .issue, .rsData, .rtData,
      .wrEn, .wrAddr, .wrData, .haltReq
   );

endmodule

//--- verification/wiscCore_assert.sv
//####################
// bus protocol and decode checks
// reset quiet, one answer per request,
// no ack with err, illegal opcode gets err
//####################
module wiscCore_assert import wiscPkg::*; #(
   parameter int ADDR_WIDTH = 8
) (
   input logic                  clk,
   input logic                  rstN,
   input logic                  cyc,
   input logic                  stb,
   input logic                  we,
   input logic [ADDR_WIDTH-1:0] adr,
   input logic [15:0]           datW,
   input logic                  ack,
   input logic                  err
);
   timeunit 1ns;
   timeprecision 100ps;

   logic req;

   assign req = cyc & stb & ~ack & ~err;  // new request, not yet answered

   // opcodes the slice executes
   function automatic logic supported(input logic [4:0] op);
      case (op)
         opHalt, opNop, opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori,
         opSrli, opSlbi, opLbi, opBtr, opShift, opAlu, opSeq, opSlt, opSle, opSco:
            return 1'b1;
         default:
            return 1'b0;
      endcase
   endfunction

   resetQuiet: assert property (@(posedge clk) !rstN |=> (!ack && !err))
      else begin
         $error("ack or err high during or right after reset");
         wiscCoreTb.assertErrs++;
      end

   oneAnswer: assert property (@(posedge clk) disable iff (!rstN) req |=> (ack ^ err))
      else begin
         $error("request not answered by exactly one of ack and err");
         wiscCoreTb.assertErrs++;
      end

   noSpurious: assert property (@(posedge clk) disable iff (!rstN)
                                (ack || err) |-> $past(req))
      else begin
         $error("ack or err without a request on the previous edge");
         wiscCoreTb.assertErrs++;
      end

   notBoth: assert property (@(posedge clk) disable iff (!rstN) !(ack && err))
      else begin
         $error("ack and err high together");
         wiscCoreTb.assertErrs++;
      end

   illegalErr: assert property (@(posedge clk) disable iff (!rstN)
                                (req && we && adr == '0 && !supported(datW[15:11])) |=> err)
      else begin
         $error("unsupported opcode written without err");
         wiscCoreTb.assertErrs++;
      end

endmodule

//--- verification/wiscCoreTb.sv
//####################
// testbench for the execute slice
// clock, reset, Wishbone tasks,
// reference register model, read-back checks
//####################
module wiscCoreTb
   import wiscPkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int addrW = 8;
   localparam logic [4:0] immOps [8] = '{opAddi, opSubi, opXori, opAndni,
                                         opRoli, opSlli, opRori, opSrli};
   localparam logic [4:0] regOps [7] = '{opAlu, opShift, opBtr, opSeq,
                                         opSlt, opSle, opSco};

   logic             clk = 1'b0;
   logic             rstN, cyc, stb, we, ack, err;
   logic [addrW-1:0] adr;
   logic [15:0]      datW, datR;

   logic [15:0] model [8];     // expected register contents
   logic        halted;        // expected sticky flag
   integer      seed = 32'h61e4;
   int          valErrs = 0;   // wrong read-back values
   int          busErrs = 0;   // wrong ack/err or timeouts
   int          assertErrs = 0;  // bumped by the bound checker

   wiscCore #(.ADDR_WIDTH(addrW)) i_dut (
      .clk, .rstN, .cyc, .stb, .we, .adr, .datW, .datR, .ack, .err
   );

   bind wiscCore wiscCore_assert #(.ADDR_WIDTH(ADDR_WIDTH)) uAssert (
      .clk, .rstN, .cyc, .stb, .we, .adr, .datW, .ack, .err
   );

   always #10 clk = ~clk;  // 20 ns period

   // one classic cycle, inputs move 2 ns after the edge
   task automatic busCycle(input logic wr, input logic [addrW-1:0] a, input logic [15:0] d,
                           output logic [15:0] rdData, output logic gotErr);
      int n;
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = wr;
      adr  = a;
      datW = d;
      n    = 0;
      do begin
         @(posedge clk);
         #2;
         n++;
      end while (!ack && !err && n < 20);
      gotErr = err;
      rdData = datR;
      if (!ack && !err) begin
         $display("bus cycle to address %h got neither ack nor err in 20 cycles", a);
         busErrs++;
         gotErr = 1'b1;
      end
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      @(posedge clk);  // one idle cycle
      #2;
   endtask

   task automatic applyReset();
      rstN = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      rstN = 1'b1;
      for (int i = 0; i < 8; i++) begin
         model[i] = '0;
      end
      halted = 1'b0;
   endtask

   function automatic logic [15:0] rotl(input logic [15:0] v, input logic [3:0] n);
      return (v << n) | (v >> (5'd16 - n));  // n of 0 leaves v
   endfunction

   function automatic logic [15:0] bitRev(input logic [15:0] v);
      logic [15:0] r;
      for (int i = 0; i < 16; i++) begin
         r[i] = v[15 - i];
      end
      return r;
   endfunction

   function automatic logic supportedOp(input logic [4:0] op);
      case (op)
         opHalt, opNop, opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori,
         opSrli, opSlbi, opLbi, opBtr, opShift, opAlu, opSeq, opSlt, opSle, opSco:
            return 1'b1;
         default:
            return 1'b0;
      endcase
   endfunction

   // write one instruction, check ack/err, update the model
   task automatic issueInstr(input logic [15:0] instr);
      logic [4:0]  op;
      logic [2:0]  rs, dst;
      logic [15:0] a, b, immS, immZ, res, unused;
      logic        wr, expErr, gotErr;
      op     = instr[15:11];
      rs     = instr[10:8];
      a      = model[rs];
      b      = model[instr[7:5]];                  // rt
      immS   = {{11{instr[4]}}, instr[4:0]};
      immZ   = {11'b0, instr[4:0]};
      dst    = instr[7:5];                         // I-format rd
      res    = '0;
      wr     = supportedOp(op) && (op != opHalt) && (op != opNop);
      expErr = halted || !supportedOp(op);
      if (op inside {opAlu, opShift, opBtr, opSeq, opSlt, opSle, opSco}) begin
         dst = instr[4:2];                         // R-format rd
      end
      if (op inside {opLbi, opSlbi}) begin
         dst = rs;
      end
      case (op)
         opAddi:  res = a + immS;
         opSubi:  res = immS - a;
         opXori:  res = a ^ immZ;
         opAndni: res = a & ~immZ;
         opRoli:  res = rotl(a, instr[3:0]);
         opSlli:  res = a << instr[3:0];
         opRori:  res = rotl(a, 4'd0 - instr[3:0]);
         opSrli:  res = a >> instr[3:0];
         opAlu: begin
            case (instr[1:0])
               2'b00:   res = a + b;
               2'b01:   res = b - a;               // rt - rs
               2'b10:   res = a ^ b;
               default: res = a & ~b;
            endcase
         end
         opShift: begin
            case (instr[1:0])
               2'b00:   res = rotl(a, b[3:0]);
               2'b01:   res = a << b[3:0];
               2'b10:   res = rotl(a, 4'd0 - b[3:0]);
               default: res = a >> b[3:0];
            endcase
         end
         opBtr:   res = bitRev(a);
         opSeq:   res = {15'b0, a == b};
         opSlt:   res = {15'b0, $signed(a) < $signed(b)};
         opSle:   res = {15'b0, $signed(a) <= $signed(b)};
         opSco:   res = {15'b0, a >= b};           // rs - rt without borrow
         opLbi:   res = {{8{instr[7]}}, instr[7:0]};
         opSlbi:  res = {a[7:0], instr[7:0]};
         default: res = '0;
      endcase
      busCycle(1'b1, '0, instr, unused, gotErr);
      if (gotErr !== expErr) begin
         $display("[FAIL] err for instr %h expected %h got %h", instr, expErr, gotErr);
         busErrs++;
      end
      if (!expErr && wr) begin
         model[dst] = res;
      end
      if (!expErr && op == opHalt) begin
         halted = 1'b1;
      end
   endtask

   task automatic checkRegs();
      logic [15:0] v;
      logic        e;
      for (int i = 0; i < 8; i++) begin
         busCycle(1'b0, addrW'(8 + i), 16'h0, v, e);
         if (e) begin
            $display("read of register r%0d was answered with err", i);
            busErrs++;
         end else if (v !== model[i]) begin
            $display("[FAIL] r%0d expected %h got %h", i, model[i], v);
            valErrs++;
         end
      end
   endtask

   task automatic checkStatus(input logic expHalt);
      logic [15:0] v;
      logic        e;
      busCycle(1'b0, '0, 16'h0, v, e);
      if (e || v[statHalted] !== expHalt) begin
         $display("[FAIL] status expected %h got %h", {15'b0, expHalt}, v);
         valErrs++;
      end
   endtask

   task automatic expectReject(input logic wr, input logic [addrW-1:0] a);
      logic [15:0] v;
      logic        e;
      busCycle(wr, a, 16'h4321, v, e);
      if (!e) begin
         $display("access to address %h with we %0d was not rejected", a, wr);
         busErrs++;
      end
   endtask

   initial begin
      logic [31:0] r;
      cyc  = 1'b0;
      stb  = 1'b0;
      we   = 1'b0;
      adr  = '0;
      datW = '0;
      rstN = 1'b0;
      applyReset();
      checkRegs();                                 // all zero after reset
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         issueInstr({opLbi, 3'(i), r[7:0]});
      end
      for (int k = 0; k < 8; k++) begin
         repeat (4) begin
            r = $random(seed);
            issueInstr({immOps[k], r[10:0]});
         end
      end
      checkRegs();
      for (int i = 0; i < 8; i++) begin              // full 16-bit reload
         r = $random(seed);
         issueInstr({opLbi, 3'(i), r[7:0]});
         issueInstr({opSlbi, 3'(i), r[15:8]});
      end
      for (int k = 0; k < 7; k++) begin
         for (int j = 0; j < 4; j++) begin           // every func code
            r = $random(seed);
            issueInstr({regOps[k], r[10:2], 2'(j)});
         end
      end
      issueInstr({opSeq, 3'd2, 3'd2, 3'd5, 2'b00});  // equal operands
      checkRegs();
      for (int op = 0; op < 32; op++) begin
         if (!supportedOp(5'(op))) begin
            r = $random(seed);
            issueInstr({5'(op), r[10:0]});
         end
      end
      expectReject(1'b1, addrW'(8));
      expectReject(1'b0, addrW'(3));
      checkRegs();                                 // nothing changed
      issueInstr({opHalt, 11'b0});
      checkStatus(1'b1);
      r = $random(seed);
      issueInstr({opAddi, r[10:0]});               // halted, expect err
      applyReset();
      checkStatus(1'b0);
      checkRegs();
      $display("errors: value %0d, bus %0d, assertion %0d", valErrs, busErrs, assertErrs);
      if (valErrs + busErrs + assertErrs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- wiscCore.f
src/wiscPkg.sv
src/controlUnit.sv
src/regFile.sv
src/executeUnit.sv
src/wbSlave.sv
src/wiscCore.sv
verification/wiscCore_assert.sv
verification/wiscCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the wiscCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module wiscCoreTb \
   -f wiscCore.f -o wiscCoreSim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/wiscCoreSim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

! grep -q "FAIL: see errors above" sim.log && grep -q "PASS: all tests" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
